/* dv/ex_ref_model.svh */
// execute stage reference functions
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// ops that leave the gpr alone
function automatic logic writes_gpr(input ex_pkg::ex_op_e op);
    case (op)
        ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_MTHI, ex_pkg::OP_MTLO,
        ex_pkg::OP_MADD, ex_pkg::OP_MADDU, ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: return 1'b0;
        default: return 1'b1;
    endcase
endfunction

function automatic logic is_accumulate(input ex_pkg::ex_op_e op);
    return op == ex_pkg::OP_MADD || op == ex_pkg::OP_MADDU
        || op == ex_pkg::OP_MSUB || op == ex_pkg::OP_MSUBU;
endfunction

// low 64 bits of the extended operands give the signed product
function automatic ex_pkg::dword_t full_product(input logic sgn, input ex_pkg::word_t a,
                                               input ex_pkg::word_t b);
    ex_pkg::dword_t wa;
    ex_pkg::dword_t wb;
    wa = sgn ? {{32{a[31]}}, a} : {32'b0, a};
    wb = sgn ? {{32{b[31]}}, b} : {32'b0, b};
    return wa * wb;
endfunction

function automatic ex_pkg::count_t lead_count(input ex_pkg::word_t v, input logic ones);
    ex_pkg::count_t n;
    n = '0;
    for (int i = 31; i >= 0; i--) begin
        if (v[i] != ones) break;
        n = n + 1'b1;
    end
    return n;
endfunction

// adder sees -b for sub, overflow when its inputs agree in sign and the sum does not
function automatic logic trap_overflow(input ex_pkg::ex_op_e op, input ex_pkg::word_t a,
                                       input ex_pkg::word_t b);
    ex_pkg::word_t fed;
    ex_pkg::word_t sum;
    fed = (op == ex_pkg::OP_SUB) ? (32'd0 - b) : b;
    sum = a + fed;
    if (op != ex_pkg::OP_ADD && op != ex_pkg::OP_SUB) return 1'b0;
    return (a[31] == fed[31]) && (sum[31] != a[31]);
endfunction

function automatic ex_pkg::word_t expected_word(input ex_pkg::ex_op_e op,
        input ex_pkg::word_t a, input ex_pkg::word_t b,
        input ex_pkg::word_t hi, input ex_pkg::word_t lo);
    ex_pkg::dword_t prod;
    ex_pkg::word_t  w;
    prod = full_product(1'b1, a, b);
    case (op)
        ex_pkg::OP_OR:   w = a | b;
        ex_pkg::OP_AND:  w = a & b;
        ex_pkg::OP_XOR:  w = a ^ b;
        ex_pkg::OP_NOR:  w = ~(a | b);
        ex_pkg::OP_SLL:  w = b << a[4:0];
        ex_pkg::OP_SRL:  w = b >> a[4:0];
        ex_pkg::OP_SRA:  w = $signed(b) >>> a[4:0];
        ex_pkg::OP_ADD, ex_pkg::OP_ADDU: w = a + b;
        ex_pkg::OP_SUB, ex_pkg::OP_SUBU: w = a - b;
        ex_pkg::OP_SLT:  w = ex_pkg::word_t'($signed(a) < $signed(b));
        ex_pkg::OP_SLTU: w = ex_pkg::word_t'(a < b);
        ex_pkg::OP_CLZ:  w = ex_pkg::word_t'(lead_count(a, 1'b0));
        ex_pkg::OP_CLO:  w = ex_pkg::word_t'(lead_count(a, 1'b1));
        ex_pkg::OP_MUL:  w = prod[31:0];
        ex_pkg::OP_MFHI: w = hi;
        ex_pkg::OP_MFLO: w = lo;
        default:         w = '0;
    endcase
    return w;
endfunction

// hi/lo pair after the op, wrapping mod 2^64
function automatic ex_pkg::dword_t next_hilo(input ex_pkg::ex_op_e op,
        input ex_pkg::word_t a, input ex_pkg::word_t b,
        input ex_pkg::word_t hi, input ex_pkg::word_t lo);
    case (op)
        ex_pkg::OP_MULT:  return full_product(1'b1, a, b);
        ex_pkg::OP_MULTU: return full_product(1'b0, a, b);
        ex_pkg::OP_MTHI:  return {a, lo};
        ex_pkg::OP_MTLO:  return {hi, a};
        ex_pkg::OP_MADD:  return {hi, lo} + full_product(1'b1, a, b);
        ex_pkg::OP_MADDU: return {hi, lo} + full_product(1'b0, a, b);
        ex_pkg::OP_MSUB:  return {hi, lo} - full_product(1'b1, a, b);
        ex_pkg::OP_MSUBU: return {hi, lo} - full_product(1'b0, a, b);
        default:          return {hi, lo};
    endcase
endfunction

`endif

/* dv/ex_stage_tb.sv */
// execute stage testbench
`timescale 1ns/1ps

module ex_stage_tb;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              valid_i;
    ex_pkg::ex_op_e    op_i;
    ex_pkg::word_t     rs_data_i;
    ex_pkg::word_t     rt_data_i;
    ex_pkg::reg_addr_t dest_addr_i;
    logic              wr_en_i;
    logic              wb_valid_o;
    logic              wb_wr_en_o;
    ex_pkg::reg_addr_t wb_addr_o;
    ex_pkg::word_t     wb_data_o;
    logic              stall_o;

    // expectation for the op on the inputs, then one register deep like the dut
    logic              nxt_valid, nxt_wr, nxt_chk, nxt_stall;
    ex_pkg::reg_addr_t nxt_addr;
    ex_pkg::word_t     nxt_data;
    logic              exp_valid, exp_wr, exp_chk;
    ex_pkg::reg_addr_t exp_addr;
    ex_pkg::word_t     exp_data;

    ex_pkg::word_t shadow_hi;
    ex_pkg::word_t shadow_lo;
    int            timeout_cycles = 10;

    ex_pkg::ex_op_e alu_ops [0:15] = '{ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_XOR,
        ex_pkg::OP_NOR, ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA, ex_pkg::OP_ADD,
        ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU, ex_pkg::OP_SLT, ex_pkg::OP_SLTU,
        ex_pkg::OP_CLZ, ex_pkg::OP_CLO, ex_pkg::OP_MUL};
    ex_pkg::ex_op_e hilo_ops [0:7] = '{ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_MADD,
        ex_pkg::OP_MADDU, ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU, ex_pkg::OP_MTHI, ex_pkg::OP_MTLO};

    `include "ex_ref_model.svh"

    ex_stage ex_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .rs_data_i   (rs_data_i),
        .rt_data_i   (rt_data_i),
        .dest_addr_i (dest_addr_i),
        .wr_en_i     (wr_en_i),
        .wb_valid_o  (wb_valid_o),
        .wb_wr_en_o  (wb_wr_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o),
        .stall_o     (stall_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        exp_valid <= nxt_valid;
        exp_wr    <= nxt_wr;
        exp_chk   <= nxt_chk;
        exp_addr  <= nxt_addr;
        exp_data  <= nxt_data;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid_o == exp_valid)
        else stop_run($sformatf("ERROR %0t: wb_valid_o is %b, expected %b", $time,
                                $sampled(wb_valid_o), $sampled(exp_valid)));
    a_wb_wr: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o |-> wb_wr_en_o == exp_wr)
        else stop_run($sformatf("ERROR %0t: wb_wr_en_o is %b, expected %b", $time,
                                $sampled(wb_wr_en_o), $sampled(exp_wr)));
    a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o |-> wb_addr_o == exp_addr)
        else stop_run($sformatf("ERROR %0t: wb_addr_o is %0d, expected %0d", $time,
                                $sampled(wb_addr_o), $sampled(exp_addr)));
    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && exp_chk) |-> wb_data_o == exp_data)
        else stop_run($sformatf("ERROR %0t: wb_data_o is %h, expected %h", $time,
                                $sampled(wb_data_o), $sampled(exp_data)));
    a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall_o == nxt_stall)
        else stop_run($sformatf("ERROR %0t: stall_o is %b, expected %b", $time,
                                $sampled(stall_o), $sampled(nxt_stall)));

    // mostly sign-boundary corners, the rest random
    function automatic ex_pkg::word_t pick_operand();
        case ($urandom % 8)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    task automatic wait_for_stall();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < timeout_cycles && !seen; n++) begin
            @(negedge clk);
            seen = stall_o;
        end
        if (!seen) stop_run("timeout: stall_o never went high for an accumulate op");
    endtask

    task automatic wait_for_wb();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < timeout_cycles && !seen; n++) begin
            @(negedge clk);
            seen = wb_valid_o;
        end
        if (!seen) stop_run("timeout: wb_valid_o never pulsed after an issued op");
    endtask

    task automatic run_op(input ex_pkg::ex_op_e op, input ex_pkg::word_t a,
                          input ex_pkg::word_t b);
        ex_pkg::reg_addr_t dest;
        logic              wen;
        logic              acc;
        dest = ex_pkg::reg_addr_t'($urandom);
        wen  = ($urandom % 4) != 0;
        acc  = is_accumulate(op);
        @(posedge clk);
        valid_i     <= 1'b1;
        op_i        <= op;
        rs_data_i   <= a;
        rt_data_i   <= b;
        dest_addr_i <= dest;
        wr_en_i     <= wen;
        nxt_addr    <= dest;
        nxt_chk     <= writes_gpr(op);
        nxt_data    <= expected_word(op, a, b, shadow_hi, shadow_lo);
        nxt_wr      <= writes_gpr(op) && wen && !trap_overflow(op, a, b);
        nxt_valid   <= !acc;
        nxt_stall   <= acc;
        if (acc) begin
            wait_for_stall();
            @(posedge clk);  // second pass, inputs held
            nxt_valid <= 1'b1;
            nxt_stall <= 1'b0;
        end
        @(posedge clk);
        valid_i   <= 1'b0;
        nxt_valid <= 1'b0;
        wait_for_wb();
        {shadow_hi, shadow_lo} = next_hilo(op, a, b, shadow_hi, shadow_lo);
    endtask

    initial begin
        void'($urandom(3));
        rst_n       = 1'b0;
        valid_i     = 1'b0;
        op_i        = ex_pkg::OP_NOP;
        rs_data_i   = '0;
        rt_data_i   = '0;
        dest_addr_i = '0;
        wr_en_i     = 1'b0;
        nxt_valid   = 1'b0;
        nxt_wr      = 1'b0;
        nxt_chk     = 1'b0;
        nxt_stall   = 1'b0;
        nxt_addr    = '0;
        nxt_data    = '0;
        shadow_hi   = '0;
        shadow_lo   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        run_op(ex_pkg::OP_MFHI, pick_operand(), pick_operand());  // zero after reset
        run_op(ex_pkg::OP_MFLO, pick_operand(), pick_operand());
        for (int i = 0; i < 12; i++) begin
            foreach (alu_ops[j]) run_op(alu_ops[j], pick_operand(), pick_operand());
        end

        // overflow edges and all-zero / all-one operands
        run_op(ex_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        run_op(ex_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
        run_op(ex_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
        run_op(ex_pkg::OP_SUBU, 32'h8000_0000, 32'h0000_0001);
        run_op(ex_pkg::OP_CLZ, 32'h0000_0000, 32'h0);
        run_op(ex_pkg::OP_CLZ, 32'hffff_ffff, 32'h0);
        run_op(ex_pkg::OP_CLO, 32'h0000_0000, 32'h0);
        run_op(ex_pkg::OP_CLO, 32'hffff_ffff, 32'h0);
        run_op(ex_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0000);
        run_op(ex_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0000);

        // each hi/lo writer read back through mfhi and mflo
        for (int i = 0; i < 8; i++) begin
            foreach (hilo_ops[j]) begin
                run_op(hilo_ops[j], pick_operand(), pick_operand());
                run_op(ex_pkg::OP_MFHI, pick_operand(), pick_operand());
                run_op(ex_pkg::OP_MFLO, pick_operand(), pick_operand());
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+dv
src/ex_pkg.sv
src/ex_logic_shift.sv
src/ex_arith.sv
src/ex_mul.sv
src/ex_hilo.sv
src/ex_control.sv
src/ex_stage.sv
dv/ex_stage_tb.sv

/* src/ex_arith.sv */
// adder, compare and leading count
`timescale 1ns/1ps

module ex_arith (
    input  ex_pkg::arith_op_e op_i,
    input  ex_pkg::word_t     a_i,
    input  ex_pkg::word_t     b_i,
    output ex_pkg::word_t     result_o,
    output logic              overflow_o
);

    localparam int MSB = ex_pkg::DATA_W - 1;

    ex_pkg::word_t  b_mux;
    ex_pkg::word_t  sum;
    ex_pkg::count_t lead_cnt;
    logic           lt_signed;
    logic           lt_unsigned;

    // leading zeros, scanning down from the msb
    function automatic ex_pkg::count_t lead_zeros(input ex_pkg::word_t v);
        ex_pkg::count_t n;
        logic           hit;
        n   = '0;
        hit = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (v[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // subtract as a + (-b)
    assign b_mux = (op_i == ex_pkg::SUB || op_i == ex_pkg::SLT) ? (~b_i + 1'b1) : b_i;
    assign sum   = a_i + b_mux;

    // same-sign inputs, other-sign sum
    assign overflow_o = (a_i[MSB] == b_mux[MSB]) && (sum[MSB] != a_i[MSB]);

    assign lt_signed = (a_i[MSB] && !b_i[MSB])
                       || ((a_i[MSB] == b_i[MSB]) && sum[MSB]);
    assign lt_unsigned = a_i < b_i;

    // clo is clz of the inverted operand
    assign lead_cnt = lead_zeros((op_i == ex_pkg::CLO) ? ~a_i : a_i);

    always_comb begin
        case (op_i)
            ex_pkg::ADD,
            ex_pkg::SUB: begin
                result_o = sum;
            end
            ex_pkg::SLT: begin
                result_o = ex_pkg::word_t'(lt_signed);
            end
            ex_pkg::SLTU: begin
                result_o = ex_pkg::word_t'(lt_unsigned);
            end
            ex_pkg::CLZ,
            ex_pkg::CLO: begin
                result_o = ex_pkg::word_t'(lead_cnt);
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/ex_control.sv */
// execute stage control
`timescale 1ns/1ps

module ex_control (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_i,
    input  ex_pkg::ex_op_e                op_i,
    input  logic                          overflow_i,
    input  logic                          wr_en_i,
    output ex_pkg::logic_op_e             logic_op_o,
    output ex_pkg::arith_op_e             arith_op_o,
    output ex_pkg::res_sel_e              res_sel_o,
    output logic                          mul_signed_o,
    output logic                          hilo_we_o,
    output logic [ex_pkg::HILO_SRC_W-1:0] hilo_src_o,
    output logic                          acc_first_o,
    output logic                          acc_negate_o,
    output logic                          stall_o,
    output logic                          wr_en_o
);

    ex_pkg::acc_state_e state_q, state_d;

    logic is_acc;       // madd/maddu/msub/msubu
    logic hilo_single;  // single-cycle hi/lo write, never a gpr
    logic ovf_check;    // add and sub trap on overflow
    logic acc_second;

    always_comb begin
        logic_op_o   = ex_pkg::OR;
        arith_op_o   = ex_pkg::ADD;
        res_sel_o    = ex_pkg::RES_NONE;
        mul_signed_o = 1'b0;
        acc_negate_o = 1'b0;
        hilo_src_o   = ex_pkg::HILO_SRC_PROD;
        hilo_single  = 1'b0;
        is_acc       = 1'b0;
        ovf_check    = 1'b0;
        case (op_i)
            ex_pkg::OP_OR:    res_sel_o = ex_pkg::RES_LOGIC;
            ex_pkg::OP_AND:   begin
                res_sel_o  = ex_pkg::RES_LOGIC;
                logic_op_o = ex_pkg::AND;
            end
            ex_pkg::OP_XOR:   begin
                res_sel_o  = ex_pkg::RES_LOGIC;
                logic_op_o = ex_pkg::XOR;
            end
            ex_pkg::OP_NOR:   begin
                res_sel_o  = ex_pkg::RES_LOGIC;
                logic_op_o = ex_pkg::NOR;
            end
            ex_pkg::OP_SLL:   begin
                res_sel_o  = ex_pkg::RES_SHIFT;
                logic_op_o = ex_pkg::SLL;
            end
            ex_pkg::OP_SRL:   begin
                res_sel_o  = ex_pkg::RES_SHIFT;
                logic_op_o = ex_pkg::SRL;
            end
            ex_pkg::OP_SRA:   begin
                res_sel_o  = ex_pkg::RES_SHIFT;
                logic_op_o = ex_pkg::SRA;
            end
            ex_pkg::OP_ADD:   begin
                res_sel_o = ex_pkg::RES_ARITH;
                ovf_check = 1'b1;
            end
            ex_pkg::OP_ADDU:  res_sel_o = ex_pkg::RES_ARITH;
            ex_pkg::OP_SUB:   begin
                res_sel_o  = ex_pkg::RES_ARITH;
                arith_op_o = ex_pkg::SUB;
                ovf_check  = 1'b1;
            end
            ex_pkg::OP_SUBU:  begin
                res_sel_o  = ex_pkg::RES_ARITH;
                arith_op_o = ex_pkg::SUB;
            end
            ex_pkg::OP_SLT:   begin
                res_sel_o  = ex_pkg::RES_ARITH;
                arith_op_o = ex_pkg::SLT;
            end
            ex_pkg::OP_SLTU:  begin
                res_sel_o  = ex_pkg::RES_ARITH;
                arith_op_o = ex_pkg::SLTU;
            end
            ex_pkg::OP_CLZ:   begin
                res_sel_o  = ex_pkg::RES_ARITH;
                arith_op_o = ex_pkg::CLZ;
            end
            ex_pkg::OP_CLO:   begin
                res_sel_o  = ex_pkg::RES_ARITH;
                arith_op_o = ex_pkg::CLO;
            end
            ex_pkg::OP_MUL:   begin
                res_sel_o    = ex_pkg::RES_MUL;
                mul_signed_o = 1'b1;
            end
            ex_pkg::OP_MULT:  begin
                hilo_single  = 1'b1;
                mul_signed_o = 1'b1;
            end
            ex_pkg::OP_MULTU: hilo_single = 1'b1;
            ex_pkg::OP_MADD:  begin
                is_acc       = 1'b1;
                mul_signed_o = 1'b1;
            end
            ex_pkg::OP_MADDU: is_acc = 1'b1;
            ex_pkg::OP_MSUB:  begin
                is_acc       = 1'b1;
                mul_signed_o = 1'b1;
                acc_negate_o = 1'b1;
            end
            ex_pkg::OP_MSUBU: begin
                is_acc       = 1'b1;
                acc_negate_o = 1'b1;
            end
            ex_pkg::OP_MTHI:  begin
                hilo_single = 1'b1;
                hilo_src_o  = ex_pkg::HILO_SRC_RS_HI;
            end
            ex_pkg::OP_MTLO:  begin
                hilo_single = 1'b1;
                hilo_src_o  = ex_pkg::HILO_SRC_RS_LO;
            end
            ex_pkg::OP_MFHI,
            ex_pkg::OP_MFLO:  res_sel_o = ex_pkg::RES_HILO;
            default:          res_sel_o = ex_pkg::RES_NONE;
        endcase
        if (!valid_i) res_sel_o = ex_pkg::RES_NONE;  // bubble writes zero
        if (is_acc) hilo_src_o = ex_pkg::HILO_SRC_ACC;
    end

    // two-step accumulate: product to temp, then sum into hi/lo
    assign acc_first_o = valid_i && is_acc && (state_q == ex_pkg::ACC_IDLE);
    assign acc_second  = valid_i && is_acc && (state_q == ex_pkg::ACC_SECOND);
    assign stall_o     = acc_first_o;
    assign hilo_we_o   = (valid_i && hilo_single) || acc_second;

    assign wr_en_o = valid_i && wr_en_i && !is_acc && !hilo_single
                     && !(ovf_check && overflow_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ex_pkg::ACC_IDLE:   if (acc_first_o) state_d = ex_pkg::ACC_SECOND;
            ex_pkg::ACC_SECOND: state_d = ex_pkg::ACC_IDLE;
            default:            state_d = ex_pkg::ACC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ex_pkg::ACC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // upstream holds the op, so the second pass always clears stall
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        stall_o |=> !stall_o);

    a_we_vs_first: assert property (@(posedge clk) disable iff (!rst_n)
        !(hilo_we_o && acc_first_o));

endmodule

/* src/ex_hilo.sv */
// hi/lo and accumulate temp registers
`timescale 1ns/1ps

module ex_hilo (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we_i,
    input  logic [ex_pkg::HILO_SRC_W-1:0] src_i,
    input  logic                          acc_first_i,
    input  logic                          acc_negate_i,
    input  ex_pkg::dword_t                product_i,
    input  ex_pkg::word_t                 rs_i,
    output ex_pkg::word_t                 hi_o,
    output ex_pkg::word_t                 lo_o
);

    ex_pkg::word_t  hi_q;
    ex_pkg::word_t  lo_q;
    ex_pkg::dword_t tmp_q;   // product held between the two accumulate cycles

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (we_i) begin
            case (src_i)
                ex_pkg::HILO_SRC_PROD: begin
                    {hi_q, lo_q} <= product_i;
                end
                ex_pkg::HILO_SRC_RS_HI: begin
                    hi_q <= rs_i;  // lo kept
                end
                ex_pkg::HILO_SRC_RS_LO: begin
                    lo_q <= rs_i;  // hi kept
                end
                ex_pkg::HILO_SRC_ACC: begin
                    {hi_q, lo_q} <= tmp_q + {hi_q, lo_q};  // wraps mod 2^64
                end
                default: begin
                    hi_q <= hi_q;
                end
            endcase
        end
    end

    // msub/msubu store the negated product so the second step only adds
    always_ff @(posedge clk) begin
        if (acc_first_i) begin
            tmp_q <= acc_negate_i ? (~product_i + 1'b1) : product_i;
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

/* src/ex_logic_shift.sv */
// bitwise logic and shifter
`timescale 1ns/1ps

module ex_logic_shift (
    input  ex_pkg::logic_op_e op_i,
    input  ex_pkg::word_t     a_i,
    input  ex_pkg::word_t     b_i,
    output ex_pkg::word_t     result_o
);

    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic signed [ex_pkg::DATA_W-1:0] b_signed;

    assign shamt    = a_i[ex_pkg::SHAMT_W-1:0];  // amount from rs
    assign b_signed = b_i;

    always_comb begin
        case (op_i)
            ex_pkg::OR: begin
                result_o = a_i | b_i;
            end
            ex_pkg::AND: begin
                result_o = a_i & b_i;
            end
            ex_pkg::XOR: begin
                result_o = a_i ^ b_i;
            end
            ex_pkg::NOR: begin
                result_o = ~(a_i | b_i);
            end
            ex_pkg::SLL: begin
                result_o = b_i << shamt;
            end
            ex_pkg::SRL: begin
                result_o = b_i >> shamt;
            end
            ex_pkg::SRA: begin
                result_o = b_signed >>> shamt;  // sign fill from rt
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/ex_mul.sv */
// 32x32 multiplier
`timescale 1ns/1ps

module ex_mul (
    input  logic           signed_i,
    input  ex_pkg::word_t  a_i,
    input  ex_pkg::word_t  b_i,
    output ex_pkg::dword_t product_o
);

    localparam int MSB = ex_pkg::DATA_W - 1;

    ex_pkg::word_t  a_mag;
    ex_pkg::word_t  b_mag;
    ex_pkg::dword_t mag_prod;
    logic           negate;

    // magnitudes for signed operands
    assign a_mag = (signed_i && a_i[MSB]) ? (~a_i + 1'b1) : a_i;
    assign b_mag = (signed_i && b_i[MSB]) ? (~b_i + 1'b1) : b_i;

    assign mag_prod = ex_pkg::dword_t'(a_mag) * ex_pkg::dword_t'(b_mag);

    assign negate    = signed_i && (a_i[MSB] ^ b_i[MSB]);
    assign product_o = negate ? (~mag_prod + 1'b1) : mag_prod;

    // zero operand never gives a huge unsigned product
    a_unsigned_zero: assert final (signed_i || (a_i != '0 && b_i != '0)
                                   || !product_o[2*ex_pkg::DATA_W-1])
        else $error("unsigned product of a zero operand has msb set");

endmodule

/* src/ex_pkg.sv */
// execute stage shared types
package ex_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    // hilo write source codes
    localparam int         HILO_SRC_W     = 2;
    localparam logic [1:0] HILO_SRC_PROD  = 2'd0; // full product
    localparam logic [1:0] HILO_SRC_RS_HI = 2'd1; // mthi
    localparam logic [1:0] HILO_SRC_RS_LO = 2'd2; // mtlo
    localparam logic [1:0] HILO_SRC_ACC   = 2'd3; // temp + old hi/lo

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [2*DATA_W-1:0]   dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]            count_t;   // 0..32 leading count

    // opcode values kept from the decoder's table
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MUL   = 8'b1010_1001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_MTHI  = 8'b0001_0001,
        OP_MTLO  = 8'b0001_0011,
        OP_MFHI  = 8'b0001_0000,
        OP_MFLO  = 8'b0001_0010
    } ex_op_e;

    typedef enum logic [2:0] {
        RES_NONE, RES_LOGIC, RES_SHIFT, RES_ARITH, RES_MUL, RES_HILO
    } res_sel_e;

    typedef enum logic [2:0] {
        OR, AND, XOR, NOR, SLL, SRL, SRA
    } logic_op_e;

    typedef enum logic [2:0] {
        ADD, SUB, SLT, SLTU, CLZ, CLO
    } arith_op_e;

    typedef enum logic {
        ACC_IDLE,
        ACC_SECOND
    } acc_state_e;

endpackage

/* src/ex_stage.sv */
// execute stage top
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    op_i,
    input  ex_pkg::word_t     rs_data_i,
    input  ex_pkg::word_t     rt_data_i,
    input  ex_pkg::reg_addr_t dest_addr_i,
    input  logic              wr_en_i,
    output logic              wb_valid_o,
    output logic              wb_wr_en_o,
    output ex_pkg::reg_addr_t wb_addr_o,
    output ex_pkg::word_t     wb_data_o,
    output logic              stall_o
);

    ex_pkg::logic_op_e             logic_op;
    ex_pkg::arith_op_e             arith_op;
    ex_pkg::res_sel_e              res_sel;
    logic                          mul_signed;
    logic                          hilo_we;
    logic [ex_pkg::HILO_SRC_W-1:0] hilo_src;
    logic                          acc_first;
    logic                          acc_negate;
    logic                          wr_en;
    logic                          overflow;

    ex_pkg::word_t  logic_res;
    ex_pkg::word_t  arith_res;
    ex_pkg::dword_t product;
    ex_pkg::word_t  hi;
    ex_pkg::word_t  lo;
    ex_pkg::word_t  hilo_word;
    ex_pkg::word_t  result;

    ex_control ex_control_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .overflow_i   (overflow),
        .wr_en_i      (wr_en_i),
        .logic_op_o   (logic_op),
        .arith_op_o   (arith_op),
        .res_sel_o    (res_sel),
        .mul_signed_o (mul_signed),
        .hilo_we_o    (hilo_we),
        .hilo_src_o   (hilo_src),
        .acc_first_o  (acc_first),
        .acc_negate_o (acc_negate),
        .stall_o      (stall_o),
        .wr_en_o      (wr_en)
    );

    ex_logic_shift ex_logic_shift_inst (
        .op_i     (logic_op),
        .a_i      (rs_data_i),
        .b_i      (rt_data_i),
        .result_o (logic_res)
    );

    ex_arith ex_arith_inst (
        .op_i       (arith_op),
        .a_i        (rs_data_i),
        .b_i        (rt_data_i),
        .result_o   (arith_res),
        .overflow_o (overflow)
    );

    ex_mul ex_mul_inst (
        .signed_i  (mul_signed),
        .a_i       (rs_data_i),
        .b_i       (rt_data_i),
        .product_o (product)
    );

    ex_hilo ex_hilo_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .we_i         (hilo_we),
        .src_i        (hilo_src),
        .acc_first_i  (acc_first),
        .acc_negate_i (acc_negate),
        .product_i    (product),
        .rs_i         (rs_data_i),
        .hi_o         (hi),
        .lo_o         (lo)
    );

    assign hilo_word = (op_i == ex_pkg::OP_MFHI) ? hi : lo;

    always_comb begin
        case (res_sel)
            ex_pkg::RES_LOGIC,
            ex_pkg::RES_SHIFT: result = logic_res;
            ex_pkg::RES_ARITH: result = arith_res;
            ex_pkg::RES_MUL:   result = product[ex_pkg::DATA_W-1:0];  // low word for mul
            ex_pkg::RES_HILO:  result = hilo_word;
            default:           result = '0;
        endcase
    end

    // no writeback for the stalled first accumulate pass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
            wb_wr_en_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i && !stall_o;
            wb_wr_en_o <= wr_en && !stall_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= dest_addr_i;
        wb_data_o <= result;
    end

endmodule
